// ==== dv/displayTests.txt ====
# Columns: C <hex command word> | R <random pixel writes> | F <whole frames to scan> | E
# Pixel word {01, x[7:0], y[6:0], color[2:0], 0000}; fill {10, color[2:0], 0}; swap C00000.
F 1
C 400070
C 67FBB0
C 428A50
C 541E20
F 1
C C00000
F 2
C 680060
C 417C10
C 000000
F 1
C C00000
F 1
C A00000
C C00000
F 1
R 300
C C00000
F 1
R 300
C 880000
F 1
C C00000
F 2
R 200
C C00000
F 1
E

// ==== build.f ====
design/displayPkg.sv
design/pixelMemory.sv
design/pixelCommandDecoder.sv
design/frameBuffer.sv
design/scanOut.sv
design/displayTop.sv
dv/displayChecker.sv
dv/displayTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= displayTb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= build.f
VFLAGS ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) dv/displayTests.txt
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/displayTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayTb import displayPkg::*;
();

localparam string testsPath = "dv/displayTests.txt";

logic clk;
logic reset;
logic cmdValid;
displayCmd_t cmdWord;
logic displayEnable;
logic busy;
logic rangeError;
logic frameStart;
logic pixelValid;
color_t pixelColor;

logic [31:0] rngState; // Xorshift state.
int watchdogCycles = 0; // Zero until the file is scanned.
int expectedFrames = 0;
int tbErrors = 0;
int pixelErrors;
int rangeErrors;
int timingErrors;
int framesSeen;
int pixelsChecked;
bit fileOk;
bit sawEnd;

displayTop i_displayTop
(
	.clk(clk),
	.reset(reset),
	.cmdValid(cmdValid),
	.cmdWord(cmdWord),
	.displayEnable(displayEnable),
	.busy(busy),
	.rangeError(rangeError),
	.frameStart(frameStart),
	.pixelValid(pixelValid),
	.pixelColor(pixelColor)
);

displayChecker i_displayChecker
(
	.clk(clk),
	.reset(reset),
	.cmdValid(cmdValid),
	.cmdWord(cmdWord),
	.busy(busy),
	.rangeError(rangeError),
	.frameStart(frameStart),
	.pixelValid(pixelValid),
	.pixelColor(pixelColor),
	.pixelErrors(pixelErrors),
	.rangeErrors(rangeErrors),
	.timingErrors(timingErrors),
	.framesSeen(framesSeen),
	.pixelsChecked(pixelsChecked)
);

initial
begin
	clk = 1'b0;
	forever
	begin
		#5 clk = ~clk; // 10 ns period.
	end
end

function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] s;
	s = state;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

//////////////////////////////////////////////////////////////////////
// Tests file handling.
//////////////////////////////////////////////////////////////////////

// Cycle budget from frames, fills and commands.
task automatic computeBudget(output bit ok, output int cycles);
	int fd;
	int count;
	int total;
	string line;
	logic [31:0] word;
	total = 0;
	fd = $fopen(testsPath, "r");
	ok = (fd != 0);
	if (ok)
	begin
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1)
			begin
				case (line.getc(0))
					"C":
					begin
						void'($sscanf(line.substr(1, line.len() - 1), "%h", word));
						total += (word[23:22] == opFill) ? frameSize + 1 : 1;
					end
					"R":
					begin
						void'($sscanf(line.substr(1, line.len() - 1), "%d", count));
						total += count;
					end
					"F":
					begin
						void'($sscanf(line.substr(1, line.len() - 1), "%d", count));
						total += count * frameSize;
					end
					default: ; // Comments and the end marker.
				endcase
			end
		end
		$fclose(fd);
	end
	cycles = 2 * total + 1000;
endtask

task automatic waitIdle();
	while (busy)
	begin
		@(negedge clk);
	end
endtask

// One command, then a probe offered while a fill keeps busy high.
task automatic sendCommand(input logic [23:0] word);
	displayCmd_t cmd;
	displayCmd_t probe;
	cmd = word;
	@(negedge clk);
	cmdValid = 1'b1;
	cmdWord = cmd;
	@(negedge clk);
	cmdValid = 1'b0;
	if (cmd.ctrl.opcode == opFill)
	begin
		probe = '0;
		probe.pixel.opcode = opPixel;
		probe.pixel.x = 8'd5;
		probe.pixel.y = 7'd5;
		probe.pixel.color = ~cmd.ctrl.fillColor; // Must be dropped.
		cmdValid = 1'b1;
		cmdWord = probe;
		@(negedge clk);
		cmdValid = 1'b0;
	end
	waitIdle();
endtask

// Back to back writes, x and y ranges overshoot the frame on purpose.
task automatic randomBurst(input int count);
	displayCmd_t cmd;
	for (int i = 0; i < count; i++)
	begin
		cmd = '0;
		cmd.pixel.opcode = opPixel;
		rngState = xorshift32(rngState);
		cmd.pixel.x = 8'(rngState % 176);
		rngState = xorshift32(rngState);
		cmd.pixel.y = rngState[6:0];
		cmd.pixel.color = rngState[22:20];
		@(negedge clk);
		cmdValid = 1'b1;
		cmdWord = cmd;
	end
	@(negedge clk);
	cmdValid = 1'b0;
endtask

task automatic scanFrames(input int count);
	repeat (4) @(negedge clk); // Last write and swap settle first.
	displayEnable = 1'b1;
	repeat (count * frameSize) @(negedge clk);
	displayEnable = 1'b0; // Always at a frame boundary.
	expectedFrames += count;
endtask

task automatic runTests(output bit foundEnd);
	int fd;
	int count;
	string line;
	logic [31:0] word;
	foundEnd = 0;
	fd = $fopen(testsPath, "r");
	while (!foundEnd && !$feof(fd))
	begin
		line = "";
		void'($fgets(line, fd));
		if (line.len() > 0)
		begin
			case (line.getc(0))
				"C":
				begin
					void'($sscanf(line.substr(1, line.len() - 1), "%h", word));
					sendCommand(word[23:0]);
				end
				"R":
				begin
					void'($sscanf(line.substr(1, line.len() - 1), "%d", count));
					randomBurst(count);
				end
				"F":
				begin
					void'($sscanf(line.substr(1, line.len() - 1), "%d", count));
					scanFrames(count);
				end
				"E": foundEnd = 1;
				default: ;
			endcase
		end
	end
	$fclose(fd);
endtask

task automatic closingReport();
	int total;
	if (framesSeen != expectedFrames)
	begin
		tbErrors++;
		$display("** Error at %0t: saw %0d frame starts, expected %0d",
			$time, framesSeen, expectedFrames);
	end
	if (pixelsChecked != expectedFrames * frameSize)
	begin
		tbErrors++;
		$display("** Error at %0t: checked %0d pixels, expected %0d",
			$time, pixelsChecked, expectedFrames * frameSize);
	end
	total = pixelErrors + rangeErrors + timingErrors + tbErrors;
	$display("Errors: %0d pixel, %0d rangeError, %0d timing, %0d testbench; %0d frames scanned",
		pixelErrors, rangeErrors, timingErrors, tbErrors, framesSeen);
	if (total == 0)
	begin
		$display("Everything OK");
	end
	else
	begin
		$display("Something failed");
	end
endtask

//////////////////////////////////////////////////////////////////////
// Main sequence and watchdog.
//////////////////////////////////////////////////////////////////////

initial
begin
	reset = 1'b1;
	cmdValid = 1'b0;
	cmdWord = '0;
	displayEnable = 1'b0;
	rngState = 32'h370f;
	computeBudget(fileOk, watchdogCycles);
	if (!fileOk)
	begin
		$display("Could not open the tests file %s", testsPath);
		$display("Something failed");
	end
	else
	begin
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		runTests(sawEnd);
		if (!sawEnd)
		begin
			tbErrors++;
			$display("The tests file has no end marker");
		end
		repeat (4) @(negedge clk); // Drain the last pixel.
		closingReport();
	end
	$finish;
end

initial
begin
	wait (watchdogCycles > 0);
	repeat (watchdogCycles) @(posedge clk);
	$display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
	$display("Something failed");
	$finish;
end

endmodule

`default_nettype wire

// ==== dv/displayChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayChecker import displayPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input displayCmd_t cmdWord,
	input logic busy,
	input logic rangeError,
	input logic frameStart,
	input logic pixelValid,
	input color_t pixelColor,
	output int pixelErrors,
	output int rangeErrors,
	output int timingErrors,
	output int framesSeen,
	output int pixelsChecked
);

color_t model [2][frameSize]; // Both banks, indexed by bank number.
bit front; // Model front bank.
bit swapPending;
int scanAddr; // Address of the next valid pixel.
bit expectRange; // Out-of-range write taken last edge.
int busyLeft; // Busy cycles still owed to a fill.
bit busyNow; // Busy level the model expects this cycle.
int backBank;
int x;
int y;
color_t expected;

int pixelErrorCount = 0;
int rangeErrorCount = 0;
int timingErrorCount = 0;
int frameCount = 0;
int checkedCount = 0;

assign pixelErrors = pixelErrorCount;
assign rangeErrors = rangeErrorCount;
assign timingErrors = timingErrorCount;
assign framesSeen = frameCount;
assign pixelsChecked = checkedCount;

//////////////////////////////////////////////////////////////////////
// Scan side.
//////////////////////////////////////////////////////////////////////

// Data on the wire was read with the front chosen one edge ago.
task automatic checkPixel();
	if (pixelValid)
	begin
		if (scanAddr >= frameSize)
		begin
			timingErrorCount++;
			$display("** Error at %0t: pixel past the frame end without a frame start",
				$time);
		end
		else
		begin
			expected = model[front ? 1 : 0][scanAddr];
			if (pixelColor !== expected)
			begin
				pixelErrorCount++;
				$display("** Error at %0t: pixel %0d expected %0d got %0d",
					$time, scanAddr, expected, pixelColor);
			end
			checkedCount++;
		end
		scanAddr++;
	end
endtask

task automatic trackFrameStart();
	if (frameStart)
	begin
		if (scanAddr != 0 && scanAddr != frameSize)
		begin
			timingErrorCount++;
			$display("** Error at %0t: frame start after %0d pixels", $time, scanAddr);
		end
		frameCount++;
		scanAddr = 0;
		if (swapPending)
		begin
			front = !front; // New front serves this frame's first read.
			swapPending = 0;
		end
	end
endtask

//////////////////////////////////////////////////////////////////////
// Command side.
//////////////////////////////////////////////////////////////////////

task automatic checkRangeError();
	if (rangeError !== expectRange)
	begin
		rangeErrorCount++;
		$display("** Error at %0t: rangeError is %b, expected %b",
			$time, rangeError, expectRange);
	end
	expectRange = 0;
endtask

// Busy spans the fill strobe cycle plus one cycle per pixel.
task automatic checkBusy();
	busyNow = (busyLeft > 0);
	if (busy !== busyNow)
	begin
		timingErrorCount++;
		$display("** Error at %0t: busy is %b, expected %b", $time, busy, busyNow);
	end
	if (busyLeft > 0)
	begin
		busyLeft--;
	end
endtask

task automatic applyCommand();
	if (cmdValid && !busyNow)
	begin
		backBank = front ? 0 : 1; // Writes only go to the back.
		case (cmdWord.pixel.opcode)
			opPixel:
			begin
				x = int'(cmdWord.pixel.x);
				y = int'(cmdWord.pixel.y);
				if (x < frameWidth && y < frameHeight)
				begin
					model[backBank][y * frameWidth + x] = cmdWord.pixel.color;
				end
				else
				begin
					expectRange = 1; // Pulse due next cycle and nothing written.
				end
			end
			opFill:
			begin
				for (int i = 0; i < frameSize; i++)
				begin
					model[backBank][i] = cmdWord.ctrl.fillColor;
				end
				busyLeft = frameSize + 1;
			end
			opSwap: swapPending = 1;
			default: ; // Nop.
		endcase
	end
endtask

always @(posedge clk)
begin
	if (reset)
	begin
		front = 0;
		swapPending = 0;
		scanAddr = 0;
		expectRange = 0;
		busyLeft = 0;
		busyNow = 0;
		for (int b = 0; b < 2; b++)
		begin
			for (int i = 0; i < frameSize; i++)
			begin
				model[b][i] = '0; // Banks power up black.
			end
		end
	end
	else
	begin
		checkPixel();
		trackFrameStart();
		checkRangeError();
		checkBusy();
		applyCommand();
	end
end

endmodule

`default_nettype wire

// ==== design/displayTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayTop import displayPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input displayCmd_t cmdWord,
	input logic displayEnable,
	output logic busy,
	output logic rangeError,
	output logic frameStart,
	output logic pixelValid,
	output color_t pixelColor
);

// Decoder to frame buffer.
logic writeStrobe;
pixelAddr_t writeAddr;
color_t writeColor;
logic fillStrobe;
color_t fillColor;
logic swapStrobe;
logic fillBusy;

// Scan side.
pixelAddr_t readAddr;
color_t readColor;

pixelCommandDecoder i_pixelCommandDecoder
(
	.clk(clk),
	.reset(reset),
	.cmdValid(cmdValid),
	.cmdWord(cmdWord),
	.fillBusy(fillBusy),
	.busy(busy),
	.rangeError(rangeError),
	.writeStrobe(writeStrobe),
	.writeAddr(writeAddr),
	.writeColor(writeColor),
	.fillStrobe(fillStrobe),
	.fillColor(fillColor),
	.swapStrobe(swapStrobe)
);

frameBuffer i_frameBuffer
(
	.clk(clk),
	.reset(reset),
	.writeStrobe(writeStrobe),
	.writeAddr(writeAddr),
	.writeColor(writeColor),
	.fillStrobe(fillStrobe),
	.fillColor(fillColor),
	.swapStrobe(swapStrobe),
	.frameStart(frameStart), // Swap point.
	.readAddr(readAddr),
	.fillBusy(fillBusy),
	.readColor(readColor)
);

scanOut i_scanOut
(
	.clk(clk),
	.reset(reset),
	.displayEnable(displayEnable),
	.readColor(readColor),
	.readAddr(readAddr),
	.frameStart(frameStart),
	.pixelValid(pixelValid),
	.pixelColor(pixelColor)
);

endmodule

`default_nettype wire

// ==== design/scanOut.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanOut import displayPkg::*;
(
	input logic clk,
	input logic reset,
	input logic displayEnable,
	input color_t readColor,
	output pixelAddr_t readAddr,
	output logic frameStart,
	output logic pixelValid,
	output color_t pixelColor
);

pixelAddr_t scanAddr; // Raster position, row major.
logic lastPixel;

assign readAddr = scanAddr;
assign lastPixel = (scanAddr == pixelAddr_t'(frameSize - 1));

// Only while scanning, otherwise it would sit high at address zero.
assign frameStart = displayEnable && (scanAddr == '0);

//////////////////////////////////////////////////////////////////////
// Raster counter.
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
	if (reset)
	begin
		scanAddr <= '0;
	end
	else if (displayEnable)
	begin
		if (lastPixel)
		begin
			scanAddr <= '0; // Wrap to the next frame.
		end
		else
		begin
			scanAddr <= scanAddr + 1'b1;
		end
	end
end

// Enable delayed to line up with the registered RAM read.
always_ff @(posedge clk)
begin
	if (reset)
	begin
		pixelValid <= 1'b0;
	end
	else
	begin
		pixelValid <= displayEnable;
	end
end

assign pixelColor = readColor; // Already registered in the bank.

endmodule

`default_nettype wire

// ==== design/frameBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameBuffer import displayPkg::*;
(
	input logic clk,
	input logic reset,
	input logic writeStrobe,
	input pixelAddr_t writeAddr,
	input color_t writeColor,
	input logic fillStrobe,
	input color_t fillColor,
	input logic swapStrobe,
	input logic frameStart,
	input pixelAddr_t readAddr,
	output logic fillBusy,
	output color_t readColor
);

logic front; // Bank being scanned.
logic swapPending; // Swap waits for frame start.
logic frontNext; // Front select including a swap taken this cycle.
logic readSel; // Front select that goes with the read data.

pixelAddr_t fillAddr;
color_t fillValue;

logic bankWriteEnable;
pixelAddr_t bankWriteAddr;
color_t bankWriteColor;
logic [1:0] bankWe;
color_t bankReadColor [2];

//////////////////////////////////////////////////////////////////////
// Front and back tracking.
//////////////////////////////////////////////////////////////////////

// The first read of a frame already sees the new front.
assign frontNext = front ^ (frameStart && swapPending);

always_ff @(posedge clk)
begin
	if (reset)
	begin
		front <= 1'b0;
		swapPending <= 1'b0;
		readSel <= 1'b0;
	end
	else
	begin
		front <= frontNext;
		readSel <= frontNext; // Tracks the registered read.
		if (frameStart && swapPending)
		begin
			swapPending <= 1'b0; // Swap done.
		end
		if (swapStrobe)
		begin
			swapPending <= 1'b1;
		end
	end
end

//////////////////////////////////////////////////////////////////////
// Fill sequencer.
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk)
begin
	if (reset)
	begin
		fillBusy <= 1'b0;
		fillAddr <= '0;
	end
	else if (fillStrobe)
	begin
		fillBusy <= 1'b1; // Rises the cycle after the strobe.
		fillAddr <= '0;
	end
	else if (fillBusy)
	begin
		if (fillAddr == pixelAddr_t'(frameSize - 1))
		begin
			fillBusy <= 1'b0; // Last pixel written this cycle.
		end
		else
		begin
			fillAddr <= fillAddr + 1'b1;
		end
	end
end

always_ff @(posedge clk)
begin
	if (fillStrobe)
	begin
		fillValue <= fillColor;
	end
end

//////////////////////////////////////////////////////////////////////
// Bank steering.
//////////////////////////////////////////////////////////////////////

// Sequencer owns the write port while it runs.
assign bankWriteEnable = fillBusy || writeStrobe;
assign bankWriteAddr = fillBusy ? fillAddr : writeAddr;
assign bankWriteColor = fillBusy ? fillValue : writeColor;

// Writes only reach the back bank.
assign bankWe = {bankWriteEnable && !front, bankWriteEnable && front};

for (genvar bank = 0; bank < 2; bank++)
begin : g_bank
	pixelMemory i_pixelMemory
	(
		.clk(clk),
		.writeEnable(bankWe[bank]),
		.writeAddr(bankWriteAddr),
		.writeColor(bankWriteColor),
		.readAddr(readAddr), // Both banks read, mux picks the front.
		.readColor(bankReadColor[bank])
	);
end

assign readColor = readSel ? bankReadColor[1] : bankReadColor[0];

endmodule

`default_nettype wire

// ==== design/pixelCommandDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelCommandDecoder import displayPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input displayCmd_t cmdWord,
	input logic fillBusy,
	output logic busy,
	output logic rangeError,
	output logic writeStrobe,
	output pixelAddr_t writeAddr,
	output color_t writeColor,
	output logic fillStrobe,
	output color_t fillColor,
	output logic swapStrobe
);

logic accept; // Command taken this cycle.
logic [1:0] opcode;
logic inRange; // Pixel coordinates inside the frame.
logic doPixel;
logic doFill;
logic doSwap;
pixelAddr_t rowBase; // y times 160.
pixelAddr_t linearAddr;

// A pending fill strobe covers the gap before the sequencer raises fillBusy.
assign busy = fillBusy || fillStrobe;
assign accept = cmdValid && !busy; // Offers while busy are dropped.

assign opcode = cmdWord.pixel.opcode; // Same bits in both views.

//////////////////////////////////////////////////////////////////////
// Pixel view decode.
//////////////////////////////////////////////////////////////////////

assign inRange = (cmdWord.pixel.x < 8'(frameWidth)) && (cmdWord.pixel.y < 7'(frameHeight));

// 160 is 128 plus 32.
assign rowBase = {1'b0, cmdWord.pixel.y, 7'b0} + {3'b0, cmdWord.pixel.y, 5'b0};
assign linearAddr = rowBase + {7'b0, cmdWord.pixel.x};

//////////////////////////////////////////////////////////////////////
// Opcode dispatch.
//////////////////////////////////////////////////////////////////////

always_comb
begin
	doPixel = 1'b0;
	doFill = 1'b0;
	doSwap = 1'b0;
	case (opcode)
		opPixel: doPixel = accept;
		opFill: doFill = accept;
		opSwap: doSwap = accept;
		opNop: ; // Taken and ignored.
	endcase
end

// Strobes are one cycle wide, the cycle after acceptance.
always_ff @(posedge clk)
begin
	if (reset)
	begin
		writeStrobe <= 1'b0;
		rangeError <= 1'b0;
		fillStrobe <= 1'b0;
		swapStrobe <= 1'b0;
	end
	else
	begin
		writeStrobe <= doPixel && inRange;
		rangeError <= doPixel && !inRange; // Nothing is written.
		fillStrobe <= doFill;
		swapStrobe <= doSwap;
	end
end

// Payload captured alongside the strobes.
always_ff @(posedge clk)
begin
	if (accept)
	begin
		writeAddr <= linearAddr;
		writeColor <= cmdWord.pixel.color;
		fillColor <= cmdWord.ctrl.fillColor; // Control view.
	end
end

endmodule

`default_nettype wire

// ==== design/pixelMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelMemory import displayPkg::*;
(
	input logic clk,
	input logic writeEnable,
	input pixelAddr_t writeAddr,
	input color_t writeColor,
	input pixelAddr_t readAddr,
	output color_t readColor
);

// One full frame, one word per pixel.
color_t mem [0:frameSize-1];

// Start black.
initial
begin
	for (int i = 0; i < frameSize; i++)
	begin
		mem[i] = '0;
	end
end

// Write port.
always_ff @(posedge clk)
begin
	if (writeEnable)
	begin
		mem[writeAddr] <= writeColor; // Lands at the end of the strobe cycle.
	end
end

// Registered read so the array maps to block RAM.
always_ff @(posedge clk)
begin
	readColor <= mem[readAddr]; // Data one cycle after the address.
end

endmodule

`default_nettype wire

// ==== design/displayPkg.sv ====
`default_nettype none

package displayPkg;

	//////////////////////////////////////////////////////////////////////
	// Frame geometry.
	//////////////////////////////////////////////////////////////////////

	localparam int frameWidth = 160; // Pixels per line.
	localparam int frameHeight = 120; // Lines per frame.
	localparam int frameSize = frameWidth * frameHeight; // 19200 pixels.
	localparam int addrWidth = 15; // Enough for frameSize.
	localparam int colorWidth = 3; // Red in the MSB, then green, then blue.

	// Opcodes in the top two bits of every command word.
	localparam logic [1:0] opNop = 2'b00;
	localparam logic [1:0] opPixel = 2'b01;
	localparam logic [1:0] opFill = 2'b10;
	localparam logic [1:0] opSwap = 2'b11;

	typedef logic [addrWidth-1:0] pixelAddr_t; // Linear pixel address.
	typedef logic [colorWidth-1:0] color_t; // One RGB pixel.

	//////////////////////////////////////////////////////////////////////
	// Command word views.
	//////////////////////////////////////////////////////////////////////

	// Single pixel write.
	typedef struct packed {
		logic [1:0] opcode;
		logic [7:0] x; // Column.
		logic [6:0] y; // Row.
		color_t color;
		logic [3:0] padding;
	} pixelCmd_t;

	// Fill, swap and nop.
	typedef struct packed {
		logic [1:0] opcode;
		color_t fillColor; // Only meaningful for opFill.
		logic [18:0] reserved;
	} ctrlCmd_t;

	// Opcode lands on bits 23:22 in both views.
	typedef union packed {
		pixelCmd_t pixel;
		ctrlCmd_t ctrl;
	} displayCmd_t;

endpackage

`default_nettype wire
